//--- dv/gb_io_chk.sv
`timescale 1ns/1ps

module gb_io_chk (
	input logic                         clk_cpu,
	input logic                         reset,
	input logic [gb_io_pkg::IRQ_N-1:0]  if_r,
	input logic [gb_io_pkg::IRQ_N-1:0]  ie_r,
	input logic                         if_wr,
	input logic                         ie_wr,
	input logic                         serial_irq,
	input logic                         ack_fall,
	input logic                         irq_n
);
	import gb_io_pkg::*;

	int fails = 0;   // failed assertions so far

	// ------------------------------------------------------------
	// overlap of IF and IE keeps irq low until a cpu write or ack clear
	a_irq_level: assert property (@(posedge clk_cpu) disable iff (reset)
		|(if_r & ie_r) && !if_wr && !ie_wr && !ack_fall |=> !irq_n)
		else begin fails++; $error("pending request lost without a write or ack"); end

	// completion pulse lands in IF bit 3 unless a cpu write or ack clear wins
	a_serial_if: assert property (@(posedge clk_cpu) disable iff (reset)
		serial_irq && !if_wr && !ack_fall |=> if_r[IRQ_SERIAL])
		else begin fails++; $error("serial_irq did not set IF bit 3"); end

	a_one_strobe: assert property (@(posedge clk_cpu) disable iff (reset)
		$onehot0({if_wr, ie_wr}))
		else begin fails++; $error("more than one write strobe high"); end

endmodule

bind irq_controller gb_io_chk i_chk (
	.clk_cpu(clk_cpu), .reset(reset), .if_r(if_r), .ie_r(ie_r),
	.if_wr(if_wr), .ie_wr(ie_wr), .serial_irq(serial_irq),
	.ack_fall(ack_fall), .irq_n(irq_n)
);

//--- dv/gb_io_tb.sv
`timescale 1ns/1ps

module gb_io_tb;
	import gb_io_pkg::*;

	localparam int N_MONO = 32;    // mono mode ops
	localparam int N_RAM  = 400;   // colour mode ram ops
	localparam int N_JOY  = 64;
	localparam int N_IRQ  = 64;
	localparam int N_EV   = 32;
	localparam int SER_LIMIT   = 8 * SERIAL_BIT_CYCLES + 4;
	localparam int OP_CYCLES   = 3 + 2*N_MONO + 2*N_RAM + 3*N_JOY + 6*N_IRQ + 3*N_EV + 40;
	localparam int CYCLE_LIMIT = 2 * (OP_CYCLES + 2*SER_LIMIT);

	logic clk_cpu;
	logic reset;
	logic is_gbc;
	logic cpu_wr;
	logic cpu_rd;
	logic irq_ack;
	logic vblank_irq;
	logic lcd_irq;
	logic timer_irq;
	logic irq_n;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic [DATA_W-1:0] joystick;
	logic [DATA_W-1:0] cpu_di;

	integer seed = 42970;
	int     errors = 0;
	int     cycles = 0;
	logic   loose;   // serial in flight so SC/IF timing not exact

	// reference model state
	logic [IRQ_N-1:0] m_if;
	logic [IRQ_N-1:0] m_ie;
	logic [1:0]       m_sel;
	logic             m_sc7;
	logic             m_sc0;
	logic             m_ack_d;
	logic [2:0]       m_svbk;
	logic [7:0]       m_h1;   // line history
	logic [7:0]       m_h2;
	int               m_ser_cnt;
	logic [DATA_W-1:0] m_wram [0:2**WRAM_AW-1];
	logic [DATA_W-1:0] m_hram [0:2**HRAM_AW-1];
	mem_region_t      exp_region;
	logic [DATA_W-1:0] exp_di;
	logic             exp_irq_n;

	gb_io i_dut (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #2 clk_cpu = ~clk_cpu;
	end

	// ------------------------------------------------------------
	// model helpers
	function automatic mem_region_t decode_addr(input logic [ADDR_W-1:0] a, input logic gbc);
		if (a == ADDR_JOYP)      return REG_JOYP;
		else if (a == ADDR_SB)   return REG_SB;
		else if (a == ADDR_SC)   return REG_SC;
		else if (a == ADDR_IF)   return REG_IF;
		else if (a == ADDR_IE)   return REG_IE;
		else if (a == ADDR_SVBK && gbc) return REG_SVBK;   // unmapped on mono
		else if (a >= ADDR_WRAM_LO && a <= ADDR_WRAM_HI) return RGN_WRAM;
		else if (a >= ADDR_HRAM_LO && a <= ADDR_HRAM_HI) return RGN_HRAM;
		return REG_NONE;
	endfunction

	// joystick bits right left down up a b select start
	function automatic logic [7:0] joy_lines(input logic [1:0] sel, input logic [7:0] j);
		logic [3:0] dir;
		logic [3:0] btn;
		dir = ~{j[2], j[3], j[1], j[0]};
		btn = ~j[7:4];
		if (sel[0]) dir = 4'hF;   // group not selected
		if (sel[1]) btn = 4'hF;
		return {dir, btn};
	endfunction

	function automatic logic [WRAM_AW-1:0] wram_index(input logic [ADDR_W-1:0] a);
		logic [2:0] bank;
		bank = is_gbc ? m_svbk : 3'd1;   // d000 is bank 1 on mono
		return {(a[12] ? bank : 3'd0), a[11:0]};
	endfunction

	function automatic logic [DATA_W-1:0] irq_vector(input logic [IRQ_N-1:0] p);
		logic [DATA_W-1:0] v;
		v = IRQ_VEC_NONE;
		for (int i = IRQ_N - 1; i >= 0; i--)
			if (p[i]) v = 8'(IRQ_VEC_BASE + IRQ_VEC_STEP * i);
		return v;
	endfunction

	function automatic logic [IRQ_N-1:0] lowest_bit(input logic [IRQ_N-1:0] p);
		logic [IRQ_N-1:0] r;
		r = '0;
		for (int i = IRQ_N - 1; i >= 0; i--)
			if (p[i]) begin
				r    = '0;
				r[i] = 1'b1;
			end
		return r;
	endfunction

	function automatic logic [DATA_W-1:0] model_read(input mem_region_t rgn,
			input logic [ADDR_W-1:0] a, input logic [7:0] lines);
		case (rgn)
			REG_JOYP: return {2'b11, m_sel, lines[7:4] & lines[3:0]};
			REG_SC:   return {m_sc7, 6'h3F, m_sc0};
			REG_IF:   return {3'b111, m_if};
			REG_IE:   return {3'b000, m_ie};
			REG_SVBK: return {5'h1F, m_svbk};
			RGN_WRAM: return m_wram[wram_index(a)];
			RGN_HRAM: return m_hram[a[HRAM_AW-1:0]];
			default:  return 8'hFF;   // SB and unmapped
		endcase
	endfunction

	// ------------------------------------------------------------
	// model with one update per rising edge
	always @(posedge clk_cpu) begin : model
		logic [IRQ_N-1:0] pend;
		logic [IRQ_N-1:0] if_nx;
		logic [7:0]       lines;
		mem_region_t      wreg;
		if (reset) begin
			m_if       = '0;
			m_ie       = '0;
			m_sel      = '0;
			m_sc7      = 1'b0;
			m_sc0      = 1'b0;
			m_ack_d    = 1'b0;
			m_svbk     = 3'd1;
			m_h1       = '1;
			m_h2       = '1;
			m_ser_cnt  = 0;
			exp_region = REG_NONE;
			exp_di     = 8'hFF;
		end else begin
			pend  = m_if & m_ie;
			lines = joy_lines(m_sel, joystick);
			wreg  = cpu_wr ? decode_addr(cpu_addr, is_gbc) : REG_NONE;
			exp_region = cpu_rd ? decode_addr(cpu_addr, is_gbc) : REG_NONE;
			exp_di = irq_ack ? irq_vector(pend) : model_read(exp_region, cpu_addr, lines);
			if_nx = m_if;
			if (vblank_irq) if_nx[IRQ_VBLANK] = 1'b1;
			if (lcd_irq)    if_nx[IRQ_LCD]    = 1'b1;
			if (timer_irq)  if_nx[IRQ_TIMER]  = 1'b1;
			if (|(m_h2 & ~m_h1)) if_nx[IRQ_JOYPAD] = 1'b1;   // line fell
			if (wreg == REG_SC) begin
				m_sc7 = cpu_wdata[7];
				m_sc0 = cpu_wdata[0];
				m_ser_cnt = (cpu_wdata[7] && cpu_wdata[0]) ? 8 * SERIAL_BIT_CYCLES : 0;
			end else if (m_ser_cnt > 0) begin
				m_ser_cnt--;
				if (m_ser_cnt == 0) begin   // transfer done
					m_sc7 = 1'b0;
					if_nx[IRQ_SERIAL] = 1'b1;
				end
			end
			if (m_ack_d && !irq_ack) if_nx = if_nx & ~lowest_bit(pend);
			if (wreg == REG_IF) if_nx = cpu_wdata[IRQ_N-1:0];   // cpu write wins
			m_if = if_nx;
			if (wreg == REG_IE)   m_ie = cpu_wdata[IRQ_N-1:0];
			if (wreg == REG_JOYP) m_sel = cpu_wdata[5:4];
			if (wreg == REG_SVBK) m_svbk = (cpu_wdata[2:0] == 3'd0) ? 3'd1 : cpu_wdata[2:0];
			if (wreg == RGN_WRAM) m_wram[wram_index(cpu_addr)] = cpu_wdata;
			if (wreg == RGN_HRAM) m_hram[cpu_addr[HRAM_AW-1:0]] = cpu_wdata;
			m_h2 = m_h1;
			m_h1 = lines;
			m_ack_d = irq_ack;
		end
		exp_irq_n = ~|(m_if & m_ie);
	end

	// ------------------------------------------------------------
	// compare tasks
	task automatic check_byte(input string what, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_region(input mem_region_t rgn, input logic [DATA_W-1:0] exp);
		if (!$isunknown(exp) && cpu_di !== exp) begin   // unwritten ram skipped
			errors++;
			$display("ERR %0t read of %s: got %02h expected %02h", $time, rgn.name(),
				cpu_di, exp);
		end
	endtask

	task automatic check_irq_n(input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t irq_n: got %b expected %b", $time, got, exp);
		end
	endtask

	// one bus cycle with the result checked at the next falling edge
	task automatic step();
		@(negedge clk_cpu);
		if (!(loose && (exp_region == REG_SC || exp_region == REG_IF)))
			check_region(exp_region, exp_di);
		check_irq_n(irq_n, exp_irq_n);
	endtask

	task automatic drive(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
			input logic w, input logic r);
		cpu_addr = a;
		cpu_wdata = d;
		cpu_wr = w;
		cpu_rd = r;
		step();
	endtask

	task automatic write_bus(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		drive(a, d, 1'b1, 1'b0);
	endtask

	task automatic read_bus(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
		drive(a, 8'h00, 1'b0, 1'b1);
		d = cpu_di;
	endtask

	task automatic idle();
		drive(16'h0000, 8'h00, 1'b0, 1'b0);
	endtask

	// ------------------------------------------------------------
	initial begin : stim
		logic [DATA_W-1:0] d;
		logic [ADDR_W-1:0] a;
		int k;
		reset      = 1'b1;
		is_gbc     = 1'b0;
		loose      = 1'b0;
		irq_ack    = 1'b0;
		joystick   = '0;
		cpu_addr   = '0;
		cpu_wdata  = '0;
		cpu_wr     = 1'b0;
		cpu_rd     = 1'b0;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		repeat (3) @(negedge clk_cpu);
		reset = 1'b0;

		// mono mode ignores svbk and d000 stays bank 1
		for (int i = 0; i < N_MONO; i++) begin
			write_bus(ADDR_SVBK, 8'($random(seed)));
			a = 16'hD000 | 16'($random(seed) & 16'h000F);
			if (i % 2 == 0) write_bus(a, 8'($random(seed)));
			else read_bus(a, d);
		end
		read_bus(ADDR_SVBK, d);
		check_byte("svbk on mono", d, 8'hFF);

		// colour mode banked wram, echo and hram
		is_gbc = 1'b1;
		read_bus(ADDR_SVBK, d);   // still bank 1 after the mono writes
		for (int i = 0; i < N_RAM; i++) begin
			k = {$random(seed)} % 8;
			if (k == 0) begin
				write_bus(ADDR_SVBK, 8'({$random(seed)} % 8));   // 0 acts as 1
				read_bus(ADDR_SVBK, d);
			end else begin
				if (k < 3)      a = ADDR_HRAM_LO + 16'({$random(seed)} % 127);
				else if (k < 6) a = 16'hC000 | 16'($random(seed) & 16'h100F);
				else            a = 16'hE000 | 16'($random(seed) & 16'h100F);   // echo
				if ($random(seed) & 1) write_bus(a, 8'($random(seed)));
				else read_bus(a, d);
			end
		end

		// joypad select and lines
		write_bus(ADDR_IF, 8'h00);
		for (int i = 0; i < N_JOY; i++) begin
			joystick = 8'($random(seed));
			write_bus(ADDR_JOYP, 8'($random(seed)));
			read_bus(ADDR_JOYP, d);
			idle();
		end
		write_bus(ADDR_JOYP, 8'h20);   // directions selected
		joystick = 8'h00;
		repeat (3) idle();
		write_bus(ADDR_IF, 8'h00);
		joystick = 8'h01;   // press right
		repeat (3) idle();
		read_bus(ADDR_IF, d);
		check_byte("joypad irq", d & 8'h10, 8'h10);
		joystick = 8'h00;
		repeat (2) idle();

		// IE/IF, vector and ack clear
		for (int i = 0; i < N_IRQ; i++) begin
			if ($random(seed) & 1) write_bus(ADDR_IE, 8'($random(seed)));
			else write_bus(ADDR_IF, 8'($random(seed)));
			read_bus(ADDR_IF, d);
			read_bus(ADDR_IE, d);
			irq_ack = 1'b1;
			idle();   // vector on cpu_di
			irq_ack = 1'b0;
			idle();   // falling edge of ack
			read_bus(ADDR_IF, d);
		end

		// event pulses
		for (int i = 0; i < N_EV; i++) begin
			{timer_irq, lcd_irq, vblank_irq} = 3'($random(seed));
			idle();
			{timer_irq, lcd_irq, vblank_irq} = 3'b000;
			read_bus(ADDR_IF, d);
			if (i % 4 == 3) write_bus(ADDR_IF, 8'h00);
		end

		// serial with internal clock
		write_bus(ADDR_IE, 8'h00);
		write_bus(ADDR_IF, 8'h00);
		write_bus(ADDR_SC, 8'h81);
		loose = 1'b1;
		d = 8'hFF;
		k = 0;
		while (d[7] && k < SER_LIMIT) begin
			read_bus(ADDR_SC, d);
			k++;
		end
		if (d[7]) begin
			errors++;
			$display("serial transfer with internal clock did not finish in %0d cycles",
				SER_LIMIT);
		end
		repeat (4) idle();
		loose = 1'b0;
		read_bus(ADDR_IF, d);
		check_byte("serial irq", d & 8'h08, 8'h08);

		// external clock never completes
		write_bus(ADDR_SC, 8'h80);
		for (int i = 0; i < SER_LIMIT; i++)
			read_bus(ADDR_SC, d);
		check_byte("sc external clock", d & 8'h80, 8'h80);

		read_bus(ADDR_SB, d);
		check_byte("sb", d, 8'hFF);
		read_bus(16'hFF03, d);
		check_byte("unmapped ff03", d, 8'hFF);
		for (int i = 0; i < 8; i++) begin
			a = 16'($random(seed) & 16'h7FFF);   // dropped cartridge space
			read_bus(a, d);
			check_byte("unmapped", d, 8'hFF);
		end

		$display("errors: %0d compare, %0d assertion", errors, i_dut.i_irq.i_chk.fails);
		if (errors == 0 && i_dut.i_irq.i_chk.fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_cpu);
			cycles++;
		end
		$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- filelist.f
source/gb_io_pkg.sv
source/cpu_bus_if.sv
source/cpu_bus_decode.sv
source/joypad_port.sv
source/serial_port.sv
source/irq_controller.sv
source/work_ram.sv
source/cpu_read_mux.sv
source/gb_io.sv
dv/gb_io_chk.sv
dv/gb_io_tb.sv

//--- source/cpu_bus_decode.sv
`timescale 1ns/1ps

module cpu_bus_decode (
	cpu_bus_if.decode               bus,
	input  logic                    is_gbc,    // colour mode, static
	output gb_io_pkg::mem_region_t  region,
	output logic                    joyp_wr,
	output logic                    sc_wr,
	output logic                    if_wr,
	output logic                    ie_wr,
	output logic                    svbk_wr,
	output logic                    wram_wr,
	output logic                    hram_wr
);
	import gb_io_pkg::*;

	logic sel_joyp;
	logic sel_sb;
	logic sel_sc;
	logic sel_if;
	logic sel_ie;
	logic sel_svbk;
	logic sel_wram;
	logic sel_hram;

	// ------------------------------------------------------------
	// address match
	assign sel_joyp = (bus.addr == ADDR_JOYP);
	assign sel_sb   = (bus.addr == ADDR_SB);
	assign sel_sc   = (bus.addr == ADDR_SC);
	assign sel_if   = (bus.addr == ADDR_IF);
	assign sel_ie   = (bus.addr == ADDR_IE);
	assign sel_svbk = (bus.addr == ADDR_SVBK) && is_gbc;   // mono has no svbk
	assign sel_wram = (bus.addr >= ADDR_WRAM_LO) && (bus.addr <= ADDR_WRAM_HI);   // incl. echo
	assign sel_hram = (bus.addr >= ADDR_HRAM_LO) && (bus.addr <= ADDR_HRAM_HI);   // ffff is IE

	// write strobes, only while cpu writes
	assign joyp_wr = bus.wr && sel_joyp;
	assign sc_wr   = bus.wr && sel_sc;
	assign if_wr   = bus.wr && sel_if;
	assign ie_wr   = bus.wr && sel_ie;
	assign svbk_wr = bus.wr && sel_svbk;
	assign wram_wr = bus.wr && sel_wram;
	assign hram_wr = bus.wr && sel_hram;

	// ------------------------------------------------------------
	// read source, one region at most
	always_comb begin
		region = REG_NONE;   // no read or unmapped
		if (bus.rd) begin
			if (sel_joyp)      region = REG_JOYP;
			else if (sel_sb)   region = REG_SB;
			else if (sel_sc)   region = REG_SC;
			else if (sel_if)   region = REG_IF;
			else if (sel_ie)   region = REG_IE;
			else if (sel_svbk) region = REG_SVBK;
			else if (sel_wram) region = RGN_WRAM;
			else if (sel_hram) region = RGN_HRAM;
		end
	end

endmodule

//--- source/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if;
	import gb_io_pkg::*;

	logic [ADDR_W-1:0] addr;    // cpu address
	logic [DATA_W-1:0] wdata;   // cpu write data
	logic              wr;      // write level for the cycle
	logic              rd;      // read level for the cycle

	// address decoder
	modport decode (
		input addr,
		input wr,
		input rd
	);

	// register and memory blocks
	modport regs (
		input addr,
		input wdata
	);

endinterface

//--- source/cpu_read_mux.sv
`timescale 1ns/1ps

module cpu_read_mux (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  gb_io_pkg::mem_region_t        region,
	input  logic                          irq_ack,
	input  logic [gb_io_pkg::DATA_W-1:0]  joyp_do,
	input  logic [gb_io_pkg::DATA_W-1:0]  sc_do,
	input  logic [gb_io_pkg::DATA_W-1:0]  if_do,
	input  logic [gb_io_pkg::DATA_W-1:0]  ie_do,
	input  logic [gb_io_pkg::DATA_W-1:0]  svbk_do,
	input  logic [gb_io_pkg::DATA_W-1:0]  irq_vec,
	input  logic [gb_io_pkg::DATA_W-1:0]  wram_do,   // registered in the ram
	input  logic [gb_io_pkg::DATA_W-1:0]  hram_do,
	output logic [gb_io_pkg::DATA_W-1:0]  cpu_di
);
	import gb_io_pkg::*;

	mem_region_t       region_q;
	logic              ack_q;
	logic [DATA_W-1:0] reg_sel;   // register byte for this cycle
	logic [DATA_W-1:0] reg_q;

	always_comb begin
		if (irq_ack)
			reg_sel = irq_vec;   // vector replaces read data
		else begin
			case (region)
				REG_JOYP: reg_sel = joyp_do;
				REG_SC:   reg_sel = sc_do;
				REG_IF:   reg_sel = if_do;
				REG_IE:   reg_sel = ie_do;
				REG_SVBK: reg_sel = svbk_do;
				default:  reg_sel = 8'hFF;   // SB, unmapped and ram
			endcase
		end
	end

	// same latency as the ram reads
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			region_q <= REG_NONE;
			ack_q    <= 1'b0;
			reg_q    <= 8'hFF;
		end else begin
			region_q <= region;
			ack_q    <= irq_ack;
			reg_q    <= reg_sel;
		end
	end

	assign cpu_di = ack_q                  ? reg_q   :
	                (region_q == RGN_WRAM) ? wram_do :
	                (region_q == RGN_HRAM) ? hram_do :
	                reg_q;

endmodule

//--- source/gb_io.sv
`timescale 1ns/1ps

module gb_io (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic                          is_gbc,
	input  logic [gb_io_pkg::ADDR_W-1:0]  cpu_addr,
	input  logic [gb_io_pkg::DATA_W-1:0]  cpu_wdata,
	input  logic                          cpu_wr,
	input  logic                          cpu_rd,
	input  logic                          irq_ack,
	input  logic [gb_io_pkg::DATA_W-1:0]  joystick,
	input  logic                          vblank_irq,
	input  logic                          lcd_irq,
	input  logic                          timer_irq,
	output logic [gb_io_pkg::DATA_W-1:0]  cpu_di,
	output logic                          irq_n
);
	import gb_io_pkg::*;

	cpu_bus_if bus ();

	mem_region_t       region;
	logic              joyp_wr;
	logic              sc_wr;
	logic              if_wr;
	logic              ie_wr;
	logic              svbk_wr;
	logic              wram_wr;
	logic              hram_wr;
	logic              joy_fall;
	logic              serial_irq;
	logic [DATA_W-1:0] joyp_do;
	logic [DATA_W-1:0] sc_do;
	logic [DATA_W-1:0] if_do;
	logic [DATA_W-1:0] ie_do;
	logic [DATA_W-1:0] svbk_do;
	logic [DATA_W-1:0] irq_vec;
	logic [DATA_W-1:0] wram_do;
	logic [DATA_W-1:0] hram_do;

	assign bus.addr  = cpu_addr;
	assign bus.wdata = cpu_wdata;
	assign bus.wr    = cpu_wr;
	assign bus.rd    = cpu_rd;

	// ------------------------------------------------------------
	cpu_bus_decode i_decode (
		.bus(bus.decode), .is_gbc(is_gbc), .region(region),
		.joyp_wr(joyp_wr), .sc_wr(sc_wr), .if_wr(if_wr), .ie_wr(ie_wr),
		.svbk_wr(svbk_wr), .wram_wr(wram_wr), .hram_wr(hram_wr)
	);

	joypad_port i_joypad (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus.regs), .joyp_wr(joyp_wr),
		.joystick(joystick), .joyp_do(joyp_do), .joy_fall(joy_fall)
	);

	serial_port i_serial (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus.regs), .sc_wr(sc_wr),
		.sc_do(sc_do), .serial_irq(serial_irq)
	);

	irq_controller i_irq (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus.regs), .if_wr(if_wr), .ie_wr(ie_wr),
		.irq_ack(irq_ack), .vblank_irq(vblank_irq), .lcd_irq(lcd_irq),
		.timer_irq(timer_irq), .serial_irq(serial_irq), .joy_fall(joy_fall),
		.if_do(if_do), .ie_do(ie_do), .irq_vec(irq_vec), .irq_n(irq_n)
	);

	work_ram i_wram (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus.regs), .wram_wr(wram_wr),
		.hram_wr(hram_wr), .svbk_wr(svbk_wr), .svbk_do(svbk_do),
		.wram_do(wram_do), .hram_do(hram_do)
	);

	cpu_read_mux i_rdmux (
		.clk_cpu(clk_cpu), .reset(reset), .region(region), .irq_ack(irq_ack),
		.joyp_do(joyp_do), .sc_do(sc_do), .if_do(if_do), .ie_do(ie_do),
		.svbk_do(svbk_do), .irq_vec(irq_vec), .wram_do(wram_do),
		.hram_do(hram_do), .cpu_di(cpu_di)
	);

endmodule

//--- source/gb_io_pkg.sv
package gb_io_pkg;

	// ------------------------------------------------------------
	// bus and block widths
	localparam int ADDR_W  = 16;   // cpu address
	localparam int DATA_W  = 8;    // cpu data
	localparam int IRQ_N   = 5;    // interrupt sources
	localparam int WRAM_AW = 15;   // 32k work ram, 8 banks of 4k
	localparam int HRAM_AW = 7;    // zero page ram

	localparam int SERIAL_BIT_CYCLES = 512;   // clk_cpu cycles per bit, 8192 Hz

	// ------------------------------------------------------------
	// register addresses
	localparam logic [ADDR_W-1:0] ADDR_JOYP = 16'hFF00;
	localparam logic [ADDR_W-1:0] ADDR_SB   = 16'hFF01;   // serial data, dummy
	localparam logic [ADDR_W-1:0] ADDR_SC   = 16'hFF02;
	localparam logic [ADDR_W-1:0] ADDR_IF   = 16'hFF0F;
	localparam logic [ADDR_W-1:0] ADDR_SVBK = 16'hFF70;   // colour mode only
	localparam logic [ADDR_W-1:0] ADDR_IE   = 16'hFFFF;

	// memory ranges, inclusive
	localparam logic [ADDR_W-1:0] ADDR_WRAM_LO = 16'hC000;
	localparam logic [ADDR_W-1:0] ADDR_WRAM_HI = 16'hFDFF;   // e000 up is the echo
	localparam logic [ADDR_W-1:0] ADDR_HRAM_LO = 16'hFF80;
	localparam logic [ADDR_W-1:0] ADDR_HRAM_HI = 16'hFFFE;

	// interrupt vectors
	localparam logic [DATA_W-1:0] IRQ_VEC_BASE = 8'h40;
	localparam int                IRQ_VEC_STEP = 8;
	localparam logic [DATA_W-1:0] IRQ_VEC_NONE = 8'h55;   // nothing pending

	// ------------------------------------------------------------
	// read source of a cycle
	typedef enum logic [3:0] {
		REG_NONE,   // unmapped, reads ff
		REG_JOYP,
		REG_SB,
		REG_SC,
		REG_IF,
		REG_IE,
		REG_SVBK,
		RGN_WRAM,
		RGN_HRAM
	} mem_region_t;

	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} serial_state_t;

	// IF / IE bit positions, lowest has highest priority
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCD    = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} irq_bit_t;

endpackage

//--- source/irq_controller.sv
`timescale 1ns/1ps

module irq_controller (
	input  logic                          clk_cpu,
	input  logic                          reset,
	cpu_bus_if.regs                       bus,
	input  logic                          if_wr,
	input  logic                          ie_wr,
	input  logic                          irq_ack,      // level from the cpu
	input  logic                          vblank_irq,   // event pulses
	input  logic                          lcd_irq,
	input  logic                          timer_irq,
	input  logic                          serial_irq,
	input  logic                          joy_fall,
	output logic [gb_io_pkg::DATA_W-1:0]  if_do,
	output logic [gb_io_pkg::DATA_W-1:0]  ie_do,
	output logic [gb_io_pkg::DATA_W-1:0]  irq_vec,
	output logic                          irq_n
);
	import gb_io_pkg::*;

	logic [IRQ_N-1:0] if_r;
	logic [IRQ_N-1:0] ie_r;
	logic [IRQ_N-1:0] pending;    // requested and enabled
	logic [IRQ_N-1:0] ack_clr;    // lowest pending bit only
	logic [IRQ_N-1:0] if_next;
	logic             ack_d;      // irq_ack at the last edge
	logic             ack_fall;

	assign pending = if_r & ie_r;
	assign irq_n   = ~|pending;
	assign ack_clr = pending & (~pending + 1'b1);   // isolate lowest set bit
	assign ack_fall = ack_d && !irq_ack;

	// unused upper bits read 1 in IF, 0 in IE
	assign if_do = {{(DATA_W-IRQ_N){1'b1}}, if_r};
	assign ie_do = {{(DATA_W-IRQ_N){1'b0}}, ie_r};

	// ------------------------------------------------------------
	// vector of the highest priority request
	always_comb begin
		irq_vec = IRQ_VEC_NONE;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (pending[i])
				irq_vec = DATA_W'(IRQ_VEC_BASE + IRQ_VEC_STEP * i);
		end
	end

	// ------------------------------------------------------------
	// IF update: events, then ack clear, cpu write wins
	always_comb begin
		if_next = if_r;
		if (vblank_irq) if_next[IRQ_VBLANK] = 1'b1;
		if (lcd_irq)    if_next[IRQ_LCD]    = 1'b1;
		if (timer_irq)  if_next[IRQ_TIMER]  = 1'b1;
		if (serial_irq) if_next[IRQ_SERIAL] = 1'b1;
		if (joy_fall)   if_next[IRQ_JOYPAD] = 1'b1;
		if (ack_fall)
			if_next = if_next & ~ack_clr;   // end of acknowledge cycle
		if (if_wr)
			if_next = bus.wdata[IRQ_N-1:0];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			ack_d <= 1'b0;
		end else begin
			if_r  <= if_next;
			ack_d <= irq_ack;
			if (ie_wr)
				ie_r <= bus.wdata[IRQ_N-1:0];
		end
	end

endmodule

//--- source/joypad_port.sv
`timescale 1ns/1ps

module joypad_port (
	input  logic                          clk_cpu,
	input  logic                          reset,
	cpu_bus_if.regs                       bus,
	input  logic                          joyp_wr,
	input  logic [gb_io_pkg::DATA_W-1:0]  joystick,   // active high presses
	output logic [gb_io_pkg::DATA_W-1:0]  joyp_do,
	output logic                          joy_fall    // any P10..P13 line fell
);
	import gb_io_pkg::*;

	logic [1:0] p54;        // select bits 5:4, low selects a group
	logic [3:0] dir_nib;    // P14 group
	logic [3:0] btn_nib;    // P15 group
	logic [7:0] hist_d1;
	logic [7:0] hist_d2;

	// right, left, up, down -> bits 0..3, inverted
	assign dir_nib = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	// a, b, select, start -> bits 0..3, inverted
	assign btn_nib = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	assign joyp_do = {2'b11, p54, dir_nib & btn_nib};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54     <= 2'b00;
			hist_d1 <= '1;   // idle lines are high
			hist_d2 <= '1;
		end else begin
			if (joyp_wr)
				p54 <= bus.wdata[5:4];
			hist_d1 <= {dir_nib, btn_nib};
			hist_d2 <= hist_d1;
		end
	end

	// 1 -> 0 on any line of either group
	assign joy_fall = |(hist_d2 & ~hist_d1);

endmodule

//--- source/serial_port.sv
`timescale 1ns/1ps

module serial_port (
	input  logic                          clk_cpu,
	input  logic                          reset,
	cpu_bus_if.regs                       bus,
	input  logic                          sc_wr,
	output logic [gb_io_pkg::DATA_W-1:0]  sc_do,
	output logic                          serial_irq   // one cycle on completion
);
	import gb_io_pkg::*;

	localparam int DIV_W = $clog2(SERIAL_BIT_CYCLES);

	serial_state_t    state;
	logic             sc_start;       // SC bit 7
	logic             sc_shiftclk;    // SC bit 0, internal clock
	logic [DIV_W-1:0] clk_div;        // cycles within a bit
	logic [2:0]       bit_cnt;        // bits shifted so far
	logic             bit_end;

	assign sc_do   = {sc_start, 6'h3F, sc_shiftclk};
	assign bit_end = (clk_div == DIV_W'(SERIAL_BIT_CYCLES - 1));

	always_ff @(posedge clk_cpu) begin
		serial_irq <= 1'b0;
		if (reset) begin
			state       <= SER_IDLE;
			sc_start    <= 1'b0;
			sc_shiftclk <= 1'b0;
			clk_div     <= '0;
			bit_cnt     <= '0;
		end else if (sc_wr) begin   // cpu write restarts any transfer
			sc_start    <= bus.wdata[7];
			sc_shiftclk <= bus.wdata[0];
			clk_div     <= '0;
			bit_cnt     <= '0;
			// external clock never arrives, stays idle
			state <= (bus.wdata[7] && bus.wdata[0]) ? SER_SHIFT : SER_IDLE;
		end else if (state == SER_SHIFT) begin
			clk_div <= clk_div + 1'b1;
			if (bit_end) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7) begin   // eighth bit done
					state      <= SER_IDLE;
					sc_start   <= 1'b0;
					serial_irq <= 1'b1;
				end
			end
		end
	end

endmodule

//--- source/work_ram.sv
`timescale 1ns/1ps

module work_ram (
	input  logic                          clk_cpu,
	input  logic                          reset,
	cpu_bus_if.regs                       bus,
	input  logic                          wram_wr,
	input  logic                          hram_wr,
	input  logic                          svbk_wr,   // already gated by colour mode
	output logic [gb_io_pkg::DATA_W-1:0]  svbk_do,
	output logic [gb_io_pkg::DATA_W-1:0]  wram_do,
	output logic [gb_io_pkg::DATA_W-1:0]  hram_do
);
	import gb_io_pkg::*;

	logic [DATA_W-1:0]  wram [2**WRAM_AW];   // 8 banks of 4k
	logic [DATA_W-1:0]  hram [2**HRAM_AW];   // ff80..fffe, top byte unused
	logic [2:0]         svbk;                // bank for d000..dfff, 1..7
	logic [WRAM_AW-1:0] wram_addr;
	logic [HRAM_AW-1:0] hram_addr;

	// ------------------------------------------------------------
	// bank select, c000/e000 page is always bank 0
	assign wram_addr = {(bus.addr[12] ? svbk : 3'd0), bus.addr[11:0]};
	assign hram_addr = bus.addr[HRAM_AW-1:0];

	assign svbk_do = {5'h1F, svbk};

	always_ff @(posedge clk_cpu) begin
		if (reset)
			svbk <= 3'd1;
		else if (svbk_wr) begin
			if (bus.wdata[2:0] == 3'd0)   // bank 0 maps to 1
				svbk <= 3'd1;
			else
				svbk <= bus.wdata[2:0];
		end
	end

	// ------------------------------------------------------------
	// single port rams, one cycle read
	always_ff @(posedge clk_cpu) begin
		if (wram_wr)
			wram[wram_addr] <= bus.wdata;
		wram_do <= wram[wram_addr];   // old data on same-address write
	end

	always_ff @(posedge clk_cpu) begin
		if (hram_wr)
			hram[hram_addr] <= bus.wdata;
		hram_do <= hram[hram_addr];
	end

endmodule
